// ==== logic/fpu_pkg.sv ====
// FPU package with widths, opcode and rounding enums, and the request and commit packets
`default_nettype none

package fpu_pkg;

    localparam int xlen          = 32;
    localparam int num_warps     = 4;
    localparam int nw_width      = 2;
    localparam int uuid_width    = 16;
    localparam int nr_bits       = 5;
    localparam int pid_width     = 2;
    localparam int max_lanes     = 2;
    localparam int inst_frm_bits = 3;
    localparam int inst_fmt_bits = 2;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef enum logic {
        op_mul,
        op_misc
    } fpu_op_e;

    typedef enum logic [inst_frm_bits-1:0] {
        frm_rne = 3'd0,
        frm_rtz = 3'd1,
        frm_rdn = 3'd2,
        frm_rup = 3'd3,
        frm_rmm = 3'd4,
        frm_dyn = 3'd7
    } fpu_frm_e;

    // Sub-op of op_misc, carried in the frm field
    typedef enum logic [inst_frm_bits-1:0] {
        misc_sgnj  = 3'd0,
        misc_sgnjn = 3'd1,
        misc_sgnjx = 3'd2,
        misc_min   = 3'd3,
        misc_max   = 3'd4
    } fpu_misc_e;

    typedef struct packed {
        logic [uuid_width-1:0] uuid;
        logic [nw_width-1:0]   wid;
        logic [max_lanes-1:0]  tmask;
        logic [xlen-1:0]       pc;
        logic [nr_bits-1:0]    rd;
        logic [pid_width-1:0]  pid;
        logic                  sop;
        logic                  eop;
    } fpu_meta_t;

    typedef struct packed {
        fpu_meta_t                         meta;
        fpu_op_e                           op;
        logic [inst_frm_bits-1:0]          frm;
        logic [inst_fmt_bits-1:0]          fmt;
        logic [max_lanes-1:0][xlen-1:0]    rs1;
        logic [max_lanes-1:0][xlen-1:0]    rs2;
        logic [max_lanes-1:0][xlen-1:0]    rs3;
    } fpu_exec_t;

    typedef struct packed {
        fpu_meta_t                         meta;
        logic [max_lanes-1:0][xlen-1:0]    result;
    } fpu_commit_t;

endpackage

`default_nettype wire

// ==== logic/fpu_tag_store.sv ====
// Tag allocator for in-flight FPU packets, keeps each packet's metadata under its tag
`default_nettype none

module fpu_tag_store #(
    parameter int queue_depth = 4,
    localparam int tag_width = (queue_depth > 1) ? $clog2(queue_depth) : 1
) (
    input  wire                     clk,
    input  wire                     block_reset,

    input  wire                     acquire,
    input  wire fpu_pkg::fpu_meta_t write_meta,
    output logic [tag_width-1:0]    alloc_tag,
    output logic                    full,

    input  wire                     release_en,
    input  wire [tag_width-1:0]     rsp_tag,
    output fpu_pkg::fpu_meta_t      read_meta
);
    import fpu_pkg::*;

    logic [queue_depth-1:0] free_mask;
    fpu_meta_t              meta_table [queue_depth];

    // Lowest free entry wins
    always_comb begin
        alloc_tag = '0;
        for (int i = queue_depth - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                alloc_tag = tag_width'(i);
            end
        end
    end

    assign full = ~|free_mask;

    always_ff @(posedge clk) begin
        if (block_reset) begin
            free_mask <= '1;
        end else begin
            if (acquire) begin
                free_mask[alloc_tag] <= 1'b0;
            end
            if (release_en) begin
                free_mask[rsp_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acquire) begin
            meta_table[alloc_tag] <= write_meta;
        end
    end

    assign read_meta = meta_table[rsp_tag];

endmodule

`default_nettype wire

// ==== logic/fpu_mul_lane.sv ====
// Single precision multiplier lane in three stages, flushes subnormals and rounds by frm
`default_nettype none

module fpu_mul_lane (
    input  wire                               clk,
    input  wire                               enable,
    input  wire [fpu_pkg::xlen-1:0]           a,
    input  wire [fpu_pkg::xlen-1:0]           b,
    input  wire [fpu_pkg::inst_frm_bits-1:0]  frm,
    output logic [fpu_pkg::xlen-1:0]          result,
    output fpu_pkg::fflags_t                  fflags
);
    import fpu_pkg::*;

    localparam logic [31:0] canonical_nan = 32'h7fc0_0000;

    // Operand classes
    logic zero_a, zero_b, inf_a, inf_b, nan_a, nan_b, snan_a, snan_b;
    logic invalid;
    logic sign_p;

    assign zero_a  = (a[30:23] == 8'd0);
    assign zero_b  = (b[30:23] == 8'd0);
    assign inf_a   = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
    assign inf_b   = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
    assign nan_a   = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    assign nan_b   = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    assign snan_a  = nan_a && !a[22];
    assign snan_b  = nan_b && !b[22];
    assign invalid = snan_a || snan_b || (zero_a && inf_b) || (inf_a && zero_b);
    assign sign_p  = a[31] ^ b[31];

    logic                     s1_sign, s1_special, s1_nv;
    logic signed [9:0]        s1_exp;
    logic [23:0]              s1_ma, s1_mb;
    logic [31:0]              s1_spec_res;
    logic [inst_frm_bits-1:0] s1_frm;

    always_ff @(posedge clk) begin
        if (enable) begin
            s1_sign     <= sign_p;
            s1_exp      <= $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]}) - 10'sd127;
            s1_ma       <= {1'b1, a[22:0]};
            s1_mb       <= {1'b1, b[22:0]};
            s1_special  <= zero_a || zero_b || inf_a || inf_b || nan_a || nan_b;
            s1_nv       <= invalid;
            s1_frm      <= frm;
            if (invalid || nan_a || nan_b) begin
                s1_spec_res <= canonical_nan;
            end else if (inf_a || inf_b) begin
                s1_spec_res <= {sign_p, 8'hff, 23'd0};
            end else begin
                s1_spec_res <= {sign_p, 31'd0};
            end
        end
    end

    logic                     s2_sign, s2_special, s2_nv;
    logic signed [9:0]        s2_exp;
    logic [47:0]              s2_prod;
    logic [31:0]              s2_spec_res;
    logic [inst_frm_bits-1:0] s2_frm;

    always_ff @(posedge clk) begin
        if (enable) begin
            s2_sign     <= s1_sign;
            s2_exp      <= s1_exp;
            s2_prod     <= s1_ma * s1_mb;
            s2_special  <= s1_special;
            s2_spec_res <= s1_spec_res;
            s2_nv       <= s1_nv;
            s2_frm      <= s1_frm;
        end
    end

    // Normalize, round and pack
    logic [23:0]       mant;
    logic [24:0]       mant_r;
    logic signed [9:0] exp_n, exp_r;
    logic              guard, sticky, inexact, round_up, max_mag;
    logic [31:0]       res_c;
    fflags_t           flags_c;

    always_comb begin
        if (s2_prod[47]) begin
            mant   = s2_prod[47:24];
            guard  = s2_prod[23];
            sticky = |s2_prod[22:0];
            exp_n  = s2_exp + 10'sd1;
        end else begin
            mant   = s2_prod[46:23];
            guard  = s2_prod[22];
            sticky = |s2_prod[21:0];
            exp_n  = s2_exp;
        end
        inexact = guard | sticky;
        case (s2_frm)
            frm_rne: round_up = guard & (sticky | mant[0]);
            frm_rdn: round_up = s2_sign & inexact;
            frm_rup: round_up = ~s2_sign & inexact;
            frm_rmm: round_up = guard;
            default: round_up = 1'b0;
        endcase
        mant_r  = {1'b0, mant} + {24'd0, round_up};
        exp_r   = exp_n + $signed({9'd0, mant_r[24]});
        // Directed modes saturate to the largest finite value on overflow
        max_mag = (s2_frm == frm_rtz) || (s2_frm == frm_rdn && !s2_sign)
               || (s2_frm == frm_rup && s2_sign);
        flags_c = '0;
        if (s2_special) begin
            res_c      = s2_spec_res;
            flags_c.nv = s2_nv;
        end else if (exp_r >= 10'sd255) begin
            res_c      = max_mag ? {s2_sign, 8'hfe, 23'h7f_ffff} : {s2_sign, 8'hff, 23'd0};
            flags_c.of = 1'b1;
            flags_c.nx = 1'b1;
        end else if (exp_r <= 10'sd0) begin
            res_c      = {s2_sign, 31'd0};
            flags_c.uf = 1'b1;
            flags_c.nx = 1'b1;
        end else begin
            res_c      = {s2_sign, exp_r[7:0], mant_r[22:0]};
            flags_c.nx = inexact;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result <= res_c;
            fflags <= flags_c;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fpu_misc_lane.sv ====
// Sign injection and IEEE 754-2019 min/max for one lane, one register stage
`default_nettype none

module fpu_misc_lane (
    input  wire                      clk,
    input  wire                      enable,
    input  wire [fpu_pkg::xlen-1:0]  a,
    input  wire [fpu_pkg::xlen-1:0]  b,
    input  wire fpu_pkg::fpu_misc_e  op,
    output logic [fpu_pkg::xlen-1:0] result,
    output fpu_pkg::fflags_t         fflags
);
    import fpu_pkg::*;

    logic        nan_a, nan_b, snan_a, snan_b;
    logic        a_lt_b;
    logic [31:0] min_max;
    logic [31:0] res_c;
    fflags_t     flags_c;

    assign nan_a  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    assign nan_b  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    assign snan_a = nan_a && !a[22];
    assign snan_b = nan_b && !b[22];

    // Sign-magnitude compare, -0 orders below +0
    always_comb begin
        if (a[31] != b[31]) begin
            a_lt_b = a[31];
        end else if (a[31]) begin
            a_lt_b = a[30:0] > b[30:0];
        end else begin
            a_lt_b = a[30:0] < b[30:0];
        end
    end

    always_comb begin
        if (nan_a && nan_b) begin
            min_max = 32'h7fc0_0000;
        end else if (nan_a) begin
            min_max = b;
        end else if (nan_b) begin
            min_max = a;
        end else if (op == misc_min) begin
            min_max = a_lt_b ? a : b;
        end else begin
            min_max = a_lt_b ? b : a;
        end
    end

    always_comb begin
        flags_c = '0;
        case (op)
            misc_sgnj:  res_c = {b[31], a[30:0]};
            misc_sgnjn: res_c = {~b[31], a[30:0]};
            misc_sgnjx: res_c = {a[31] ^ b[31], a[30:0]};
            default: begin
                res_c      = min_max;
                flags_c.nv = snan_a | snan_b;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result <= res_c;
            fflags <= flags_c;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fpu_engine.sv ====
// FPU execute engine with multiply and misc lane arrays, result merge by tag
`default_nettype none

module fpu_engine #(
    parameter int num_lanes = 2,
    parameter int tag_width = 2
) (
    input  wire                                         clk,
    input  wire                                         block_reset,

    input  wire                                         req_valid,
    output logic                                        req_ready,
    input  wire fpu_pkg::fpu_op_e                       op,
    input  wire [fpu_pkg::inst_frm_bits-1:0]            frm,
    input  wire [num_lanes-1:0]                         tmask,
    input  wire [num_lanes-1:0][fpu_pkg::xlen-1:0]      rs1,
    input  wire [num_lanes-1:0][fpu_pkg::xlen-1:0]      rs2,
    input  wire [tag_width-1:0]                         req_tag,

    output logic                                        rsp_valid,
    input  wire                                         rsp_ready,
    output logic [num_lanes-1:0][fpu_pkg::xlen-1:0]     rsp_result,
    output logic                                        rsp_has_fflags,
    output fpu_pkg::fflags_t                            rsp_fflags,
    output logic [tag_width-1:0]                        rsp_tag
);
    import fpu_pkg::*;

    logic [2:0]                     mul_v;
    logic [2:0][tag_width-1:0]      mul_tag;
    logic [2:0][num_lanes-1:0]      mul_mask;
    logic                           misc_v, misc_has;
    logic [tag_width-1:0]           misc_tag;
    logic [num_lanes-1:0]           misc_mask;
    logic                           mul_issue, misc_issue;
    logic [num_lanes-1:0][xlen-1:0] mul_res, misc_res;
    fflags_t [num_lanes-1:0]        mul_ff, misc_ff;

    // A misc issued now would land together with the multiply in stage 2
    assign req_ready  = rsp_ready && !(op == op_misc && mul_v[1]);
    assign mul_issue  = req_valid && req_ready && (op == op_mul);
    assign misc_issue = req_valid && req_ready && (op == op_misc);

    always_ff @(posedge clk) begin
        if (block_reset) begin
            mul_v  <= '0;
            misc_v <= 1'b0;
        end else if (rsp_ready) begin
            mul_v  <= {mul_v[1:0], mul_issue};
            misc_v <= misc_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_ready) begin
            mul_tag  <= {mul_tag[1:0], req_tag};
            mul_mask <= {mul_mask[1:0], tmask};
        end
        if (misc_issue) begin
            misc_tag  <= req_tag;
            misc_mask <= tmask;
            misc_has  <= (frm == misc_min) || (frm == misc_max);
        end
    end

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        fpu_mul_lane mul_i (
            .clk    (clk),
            .enable (rsp_ready),
            .a      (rs1[i]),
            .b      (rs2[i]),
            .frm    (frm),
            .result (mul_res[i]),
            .fflags (mul_ff[i])
        );

        fpu_misc_lane misc_i (
            .clk    (clk),
            .enable (misc_issue && tmask[i]),
            .a      (rs1[i]),
            .b      (rs2[i]),
            .op     (fpu_misc_e'(frm)),
            .result (misc_res[i]),
            .fflags (misc_ff[i])
        );
    end

    assign rsp_valid      = mul_v[2] || misc_v;
    assign rsp_tag        = mul_v[2] ? mul_tag[2] : misc_tag;
    assign rsp_result     = mul_v[2] ? mul_res : misc_res;
    assign rsp_has_fflags = mul_v[2] || misc_has;

    // Flags only from active lanes
    always_comb begin
        rsp_fflags = '0;
        for (int i = 0; i < num_lanes; i++) begin
            if (mul_v[2] && mul_mask[2][i]) begin
                rsp_fflags = rsp_fflags | mul_ff[i];
            end else if (!mul_v[2] && misc_mask[i]) begin
                rsp_fflags = rsp_fflags | misc_ff[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fpu_unit.sv ====
// FPU execute block top, tags packets, resolves rounding mode, accumulates flags, commits
`default_nettype none

module fpu_unit #(
    parameter int num_lanes   = 2,
    parameter int queue_depth = 4
) (
    input  wire                                 clk,
    input  wire                                 block_reset,

    input  wire                                 exec_valid,
    output logic                                exec_ready,
    input  wire fpu_pkg::fpu_exec_t             exec_data,

    output logic [fpu_pkg::nw_width-1:0]        csr_read_wid,
    input  wire [fpu_pkg::inst_frm_bits-1:0]    csr_read_frm,

    output logic                                csr_write_en,
    output logic [fpu_pkg::nw_width-1:0]        csr_write_wid,
    output fpu_pkg::fflags_t                    csr_write_fflags,

    output logic                                commit_valid,
    input  wire                                 commit_ready,
    output fpu_pkg::fpu_commit_t                commit_data
);
    import fpu_pkg::*;

    localparam int tag_width = (queue_depth > 1) ? $clog2(queue_depth) : 1;

    logic                           exec_fire, rsp_fire;
    logic                           req_valid, req_ready, full;
    logic [inst_frm_bits-1:0]       req_frm;
    logic [tag_width-1:0]           alloc_tag, rsp_tag;
    logic                           rsp_valid, rsp_has_fflags;
    logic [num_lanes-1:0][xlen-1:0] rsp_result;
    fflags_t                        rsp_fflags;
    fpu_meta_t                      rsp_meta;
    fflags_t                        flag_acc [num_warps];

    assign exec_fire = exec_valid && exec_ready;
    assign rsp_fire  = rsp_valid && commit_ready;

    fpu_tag_store #(
        .queue_depth (queue_depth)
    ) tag_store_i (
        .clk         (clk),
        .block_reset (block_reset),
        .acquire     (exec_fire),
        .write_meta  (exec_data.meta),
        .alloc_tag   (alloc_tag),
        .full        (full),
        .release_en  (rsp_fire),
        .rsp_tag     (rsp_tag),
        .read_meta   (rsp_meta)
    );

    // Dynamic rounding mode only applies to multiply
    assign csr_read_wid = exec_data.meta.wid;
    assign req_frm = (exec_data.op == op_mul && exec_data.frm == frm_dyn) ?
                     csr_read_frm : exec_data.frm;

    assign req_valid  = exec_valid && !full;
    assign exec_ready = req_ready && !full;

    fpu_engine #(
        .num_lanes (num_lanes),
        .tag_width (tag_width)
    ) engine_i (
        .clk            (clk),
        .block_reset    (block_reset),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .op             (exec_data.op),
        .frm            (req_frm),
        .tmask          (exec_data.meta.tmask[num_lanes-1:0]),
        .rs1            (exec_data.rs1[num_lanes-1:0]),
        .rs2            (exec_data.rs2[num_lanes-1:0]),
        .req_tag        (alloc_tag),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (commit_ready),
        .rsp_result     (rsp_result),
        .rsp_has_fflags (rsp_has_fflags),
        .rsp_fflags     (rsp_fflags),
        .rsp_tag        (rsp_tag)
    );

    // Per-warp flags collected over the packets of one instruction
    always_ff @(posedge clk) begin
        if (block_reset) begin
            for (int w = 0; w < num_warps; w++) begin
                flag_acc[w] <= '0;
            end
        end else if (rsp_fire) begin
            if (rsp_meta.eop) begin
                flag_acc[rsp_meta.wid] <= '0;
            end else if (rsp_has_fflags) begin
                flag_acc[rsp_meta.wid] <= flag_acc[rsp_meta.wid] | rsp_fflags;
            end
        end
    end

    assign csr_write_en     = rsp_fire && rsp_meta.eop && rsp_has_fflags;
    assign csr_write_wid    = rsp_meta.wid;
    assign csr_write_fflags = flag_acc[rsp_meta.wid] | rsp_fflags;

    assign commit_valid = rsp_valid;

    always_comb begin
        commit_data = '0;
        commit_data.meta = rsp_meta;
        commit_data.result[num_lanes-1:0] = rsp_result;
    end

endmodule

`default_nettype wire

// ==== testbench/fpu_unit_tb.sv ====
// Testbench for the FPU execute block that replays packets from the data file and checks commits
`default_nettype none

module fpu_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fpu_pkg::*;

    localparam int max_entries = 64;
    localparam int queue_depth = 4;

    logic                     clk;
    logic                     block_reset;
    logic                     exec_valid;
    logic                     exec_ready;
    fpu_exec_t                exec_data;
    logic [nw_width-1:0]      csr_read_wid;
    logic [inst_frm_bits-1:0] csr_read_frm;
    logic                     csr_write_en;
    logic [nw_width-1:0]      csr_write_wid;
    fflags_t                  csr_write_fflags;
    logic                     commit_valid;
    logic                     commit_ready;
    fpu_commit_t              commit_data;

    // Expected packets by data line
    logic [0:0]               e_op    [max_entries];
    logic [inst_frm_bits-1:0] e_frm   [max_entries];
    logic [nw_width-1:0]      e_wid   [max_entries];
    logic [uuid_width-1:0]    e_uuid  [max_entries];
    logic [pid_width-1:0]     e_pid   [max_entries];
    logic                     e_sop   [max_entries];
    logic                     e_eop   [max_entries];
    logic [max_lanes-1:0]     e_tmask [max_entries];
    logic [xlen-1:0]          e_a     [max_entries][max_lanes];
    logic [xlen-1:0]          e_b     [max_entries][max_lanes];
    logic [xlen-1:0]          e_res   [max_entries][max_lanes];
    fflags_t                  e_flags [max_entries];
    logic                     e_has   [max_entries];
    logic                     committed [max_entries];

    logic [inst_frm_bits-1:0] csr_frm_table [num_warps];
    fflags_t                  acc_model [num_warps];
    int                       warp_pending [num_warps];
    logic [uuid_width-1:0]    warp_uuid [num_warps];
    int                       num_entries;
    int                       issue_idx;
    int                       commit_count;
    int                       outstanding;
    int                       errors;
    int                       cycle;
    int                       cycle_limit;
    logic                     timed_out;
    logic [31:0]              lcg_state;
    logic                     hold_seen;
    fpu_commit_t              held_data;

    always #5 clk = ~clk;

    // CSR answers in the same cycle
    assign csr_read_frm = csr_frm_table[csr_read_wid];

    fpu_unit #(
        .num_lanes   (max_lanes),
        .queue_depth (queue_depth)
    ) dut_i (
        .clk              (clk),
        .block_reset      (block_reset),
        .exec_valid       (exec_valid),
        .exec_ready       (exec_ready),
        .exec_data        (exec_data),
        .csr_read_wid     (csr_read_wid),
        .csr_read_frm     (csr_read_frm),
        .csr_write_en     (csr_write_en),
        .csr_write_wid    (csr_write_wid),
        .csr_write_fflags (csr_write_fflags),
        .commit_valid     (commit_valid),
        .commit_ready     (commit_ready),
        .commit_data      (commit_data)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic fpu_meta_t make_meta(int i);
        fpu_meta_t m;
        m       = '0;
        m.uuid  = e_uuid[i];
        m.wid   = e_wid[i];
        m.tmask = e_tmask[i];
        m.pc    = 32'h0000_1000 + {e_uuid[i], 2'b00};
        m.rd    = e_uuid[i][4:0];
        m.pid   = e_pid[i];
        m.sop   = e_sop[i];
        m.eop   = e_eop[i];
        return m;
    endfunction

    // Next instruction of a warp waits until the previous one has fully committed
    function automatic logic warp_can_issue(int i);
        return warp_pending[e_wid[i]] == 0 || warp_uuid[e_wid[i]] == e_uuid[i];
    endfunction

    task automatic report_mismatch(string name, logic [127:0] expected, logic [127:0] actual);
        $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic load_testdata();
        int    fd;
        int    n;
        string line;
        int    f [16];
        fd = $fopen("testbench/fpu_unit_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            errors++;
            return;
        end
        while (!$feof(fd) && num_entries < max_entries) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
            if (n != 16) begin
                $display("Malformed test data line: %s", line);
                errors++;
                continue;
            end
            e_op[num_entries]     = f[0];
            e_frm[num_entries]    = f[1];
            e_wid[num_entries]    = f[2];
            e_uuid[num_entries]   = f[3];
            e_pid[num_entries]    = f[4];
            e_sop[num_entries]    = f[5];
            e_eop[num_entries]    = f[6];
            e_tmask[num_entries]  = f[7];
            e_a[num_entries][0]   = f[8];
            e_b[num_entries][0]   = f[9];
            e_a[num_entries][1]   = f[10];
            e_b[num_entries][1]   = f[11];
            e_res[num_entries][0] = f[12];
            e_res[num_entries][1] = f[13];
            e_flags[num_entries]  = f[14];
            e_has[num_entries]    = f[15];
            committed[num_entries] = 1'b0;
            num_entries++;
        end
        $fclose(fd);
    endtask

    task automatic drive_inputs();
        fpu_exec_t ed;
        ed = '0;
        if (issue_idx < num_entries && warp_can_issue(issue_idx)) begin
            ed.meta = make_meta(issue_idx);
            ed.op   = fpu_op_e'(e_op[issue_idx]);
            ed.frm  = e_frm[issue_idx];
            for (int l = 0; l < max_lanes; l++) begin
                ed.rs1[l] = e_a[issue_idx][l];
                ed.rs2[l] = e_b[issue_idx][l];
            end
            exec_valid = 1'b1;
        end else begin
            exec_valid = 1'b0;
        end
        exec_data    = ed;
        commit_ready = (next_random() & 32'h0003_0000) != 0;
    endtask

    task automatic check_commit();
        int      idx;
        fflags_t exp_flags;
        idx = -1;
        for (int i = 0; i < num_entries; i++) begin
            if (e_uuid[i] == commit_data.meta.uuid && e_pid[i] == commit_data.meta.pid) begin
                idx = i;
            end
        end
        if (idx < 0 || idx >= issue_idx) begin
            $display("Unexpected commit at %0t for uuid %h pid %0d", $time,
                     commit_data.meta.uuid, commit_data.meta.pid);
            errors++;
            return;
        end
        if (committed[idx]) begin
            $display("Duplicate commit at %0t for uuid %h pid %0d", $time,
                     e_uuid[idx], e_pid[idx]);
            errors++;
            return;
        end
        committed[idx] = 1'b1;
        commit_count++;
        warp_pending[e_wid[idx]]--;
        if (commit_data.meta !== make_meta(idx)) begin
            report_mismatch("commit_data.meta", make_meta(idx), commit_data.meta);
        end
        for (int l = 0; l < max_lanes; l++) begin
            if (e_tmask[idx][l] && commit_data.result[l] !== e_res[idx][l]) begin
                report_mismatch($sformatf("commit_data.result[%0d] uuid %h", l, e_uuid[idx]),
                                e_res[idx][l], commit_data.result[l]);
            end
        end
        // Flags of one instruction gather per warp until its last packet
        exp_flags = acc_model[e_wid[idx]] | (e_has[idx] ? e_flags[idx] : fflags_t'(0));
        if (e_eop[idx] && e_has[idx]) begin
            if (csr_write_en !== 1'b1) begin
                report_mismatch("csr_write_en", 1'b1, csr_write_en);
            end else begin
                if (csr_write_wid !== e_wid[idx]) begin
                    report_mismatch("csr_write_wid", e_wid[idx], csr_write_wid);
                end
                if (csr_write_fflags !== exp_flags) begin
                    report_mismatch("csr_write_fflags", exp_flags, csr_write_fflags);
                end
            end
        end else if (csr_write_en !== 1'b0) begin
            report_mismatch("csr_write_en", 1'b0, csr_write_en);
        end
        acc_model[e_wid[idx]] = e_eop[idx] ? fflags_t'(0) : exp_flags;
    endtask

    task automatic monitor_cycle();
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d packets committed",
                     cycle, commit_count, num_entries);
            errors++;
            timed_out = 1'b1;
        end
        if (hold_seen && commit_valid && commit_data !== held_data) begin
            report_mismatch("commit_data during stall", held_data, commit_data);
        end
        hold_seen = commit_valid && !commit_ready;
        held_data = commit_data;
        if (exec_valid && exec_ready) begin
            warp_pending[e_wid[issue_idx]]++;
            warp_uuid[e_wid[issue_idx]] = e_uuid[issue_idx];
            issue_idx++;
            outstanding++;
        end
        if (commit_valid && commit_ready) begin
            check_commit();
            outstanding--;
        end else if (csr_write_en) begin
            $display("CSR write at %0t without a commit", $time);
            errors++;
        end
        if (outstanding > queue_depth) begin
            $display("More than %0d packets in flight at %0t", queue_depth, $time);
            errors++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        block_reset  = 1'b1;
        exec_valid   = 1'b0;
        exec_data    = '0;
        commit_ready = 1'b0;
        lcg_state    = 32'd35923;
        num_entries  = 0;
        issue_idx    = 0;
        commit_count = 0;
        outstanding  = 0;
        errors       = 0;
        cycle        = 0;
        timed_out    = 1'b0;
        hold_seen    = 1'b0;
        held_data    = '0;
        // Warp modes rne, rtz, rdn, rup
        for (int w = 0; w < num_warps; w++) begin
            csr_frm_table[w] = w[inst_frm_bits-1:0];
            acc_model[w]     = '0;
            warp_pending[w]  = 0;
            warp_uuid[w]     = '0;
        end
        load_testdata();
        cycle_limit = 20 * num_entries + 100;
        repeat (3) @(posedge clk);
        @(negedge clk);
        block_reset = 1'b0;
        while (!timed_out && !(issue_idx == num_entries && commit_count == num_entries)) begin
            drive_inputs();
            @(posedge clk);
            monitor_cycle();
            @(negedge clk);
        end
        if (!timed_out) begin
            for (int i = 0; i < num_entries; i++) begin
                if (!committed[i]) begin
                    $display("Missing commit for uuid %h pid %0d", e_uuid[i], e_pid[i]);
                    errors++;
                end
            end
        end
        $display("Errors: %0d, packets committed: %0d of %0d", errors, commit_count, num_entries);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/fpu_unit_testdata.txt ====
# op frm wid uuid pid sop eop tmask a0 b0 a1 b1 res0 res1 flags has_flags (hex, op 0 mul 1 misc)
# flags bits nv dz of uf nx from msb to lsb
0 0 0 0001 0 1 1 3 3fc00000 40000000 3f800001 3f800001 40400000 3f800002 01 1
0 1 0 0002 0 1 1 3 3f800001 3f800001 3fc00000 3f800001 3f800002 3fc00001 01 1
0 2 0 0003 0 1 1 3 bf800001 3f800001 3f800001 3f800001 bf800003 3f800002 01 1
0 3 1 0004 0 1 1 3 3f800001 3f800001 bf800001 3f800001 3f800003 bf800002 01 1
0 4 1 0005 0 1 1 3 3fc00000 3f800001 3f800001 3f800001 3fc00002 3f800002 01 1
0 0 2 0006 0 1 1 3 7f000000 40000000 ff000000 40000000 7f800000 ff800000 05 1
0 1 2 0007 0 1 1 3 7f000000 40000000 ff000000 40000000 7f7fffff ff7fffff 05 1
0 2 2 0008 0 1 1 3 7f000000 40000000 ff000000 40000000 7f7fffff ff800000 05 1
0 3 2 0009 0 1 1 3 7f000000 40000000 ff000000 40000000 7f800000 ff7fffff 05 1
0 0 3 000a 0 1 1 3 00800000 3f000000 80800000 3f000000 00000000 80000000 03 1
0 0 3 000b 0 1 1 3 00000000 7f800000 7f800001 3f800000 7fc00000 7fc00000 10 1
0 0 3 000c 0 1 1 3 7fc00001 3f800000 7f800000 40000000 7fc00000 7f800000 00 1
0 0 0 000d 0 1 1 3 80000000 3f800000 00000001 3f800000 80000000 00000000 00 1
0 0 0 000e 0 1 1 1 3fc00000 40000000 00000000 7f800000 40400000 00000000 00 1
0 7 3 000f 0 1 1 3 3f800001 3f800001 3fc00000 40000000 3f800003 40400000 01 1
0 7 2 0010 0 1 1 3 bf800001 3f800001 3f800001 3f800001 bf800003 3f800002 01 1
0 7 1 0011 0 1 1 3 3fc00000 3f800001 7f000000 40000000 3fc00001 7f7fffff 05 1
0 7 0 0012 0 1 1 3 3fc00000 3f800001 3f800001 3f800001 3fc00002 3f800002 01 1
1 0 0 0020 0 1 1 3 3f800000 bf800000 c0000000 40000000 bf800000 40000000 00 0
1 1 0 0021 0 1 1 3 3f800000 bf800000 40000000 40000000 3f800000 c0000000 00 0
1 2 0 0022 0 1 1 3 bf800000 bf800000 bf800000 3f800000 3f800000 bf800000 00 0
1 3 1 0023 0 1 1 3 80000000 00000000 3f800000 40000000 80000000 3f800000 00 1
1 4 1 0024 0 1 1 3 80000000 00000000 c0000000 bf800000 00000000 bf800000 00 1
1 3 2 0025 0 1 1 3 7fc00000 3f800000 7fc00000 7fc00000 3f800000 7fc00000 00 1
1 4 2 0026 0 1 1 3 7f800001 40000000 3f800000 40000000 40000000 40000000 10 1
1 7 3 0027 0 1 1 3 3f800000 40000000 c0000000 bf800000 40000000 bf800000 00 0
1 3 0 0028 0 1 1 2 7f800001 3f800000 3f800000 bf800000 00000000 bf800000 00 1
0 0 1 0030 0 1 0 3 7f000000 40000000 3f800000 40000000 7f800000 40000000 05 1
0 0 1 0030 1 0 0 3 00800000 3f000000 3fc00000 40000000 00000000 40400000 03 1
0 0 1 0030 2 0 1 3 00000000 7f800000 3f800000 3f800000 7fc00000 3f800000 10 1
1 3 3 0032 0 1 0 3 7f800001 3f800000 00000000 80000000 3f800000 80000000 10 1
1 4 3 0032 1 0 1 3 3f800000 bf800000 00000000 80000000 3f800000 00000000 00 1
1 0 2 0033 0 1 1 3 40400000 bf800000 3f800000 3f800000 c0400000 3f800000 00 0
0 1 2 0034 0 1 1 2 7f800001 3f800000 3fc00000 40000000 00000000 40400000 00 1

// ==== fpu_unit.f ====
logic/fpu_pkg.sv
logic/fpu_tag_store.sv
logic/fpu_mul_lane.sv
logic/fpu_misc_lane.sv
logic/fpu_engine.sv
logic/fpu_unit.sv
testbench/fpu_unit_tb.sv
